//--- hw/fsab_pkg.sv
/*
 * FSAB memory bus and SPAM sidechannel definitions.
 * Request mode codes, requester identifiers, credit setup and
 * the packed request and response structs for both buses.
 */
package fsab_pkg;

	localparam logic FSAB_READ  = 1'b0;
	localparam logic FSAB_WRITE = 1'b1;

	localparam logic [3:0] FSAB_DID_CPU           = 4'h0;
	localparam logic [3:0] FSAB_SUBDID_CPU_DCACHE = 4'h1;

	localparam int FSAB_CREDIT_W = 3;
	localparam logic [FSAB_CREDIT_W-1:0] FSAB_INITIAL_CREDITS = 3'd4;
	localparam int FSAB_LINE_BEATS = 8; // 64-bit beats per line fill

	typedef struct packed {
		logic        mode;
		logic [3:0]  did;
		logic [3:0]  subdid;
		logic [30:0] addr;  // byte address, 8-byte aligned
		logic [3:0]  len;   // in beats
		logic [63:0] data;
		logic [7:0]  mask;  // byte enables
	} fsab_req_t;

	typedef struct packed {
		logic [3:0]  did;
		logic [3:0]  subdid;
		logic [63:0] data;
	} fsab_rsp_t;

	// sidechannel with one transaction in flight at a time
	typedef struct packed {
		logic        r_nw;
		logic [3:0]  did;
		logic [23:0] addr;
		logic [31:0] data;
	} spam_req_t;

	localparam logic [7:0]  SPAM_TIMEOUT   = 8'hFF;
	localparam logic [31:0] SPAM_DEAD_DATA = 32'hDEADDEAD;

endpackage

//--- hw/dcache_pkg.sv
/*
 * Data cache geometry and core request type.
 * 16 direct-mapped lines of 64 bytes, split as
 * tag [31:10], index [9:6], word [5:3], half select [2].
 */
package dcache_pkg;

	localparam int N_LINES = 16;

	localparam int TAG_W  = 22;
	localparam int IDX_W  = 4;
	localparam int WORD_W = 3;

	localparam int TAG_LSB  = 10;
	localparam int IDX_LSB  = 6;
	localparam int WORD_LSB = 3;
	localparam int HALF_BIT = 2; // picks high or low 32 bits of a beat

	// bit 31 set routes the access to the sidechannel
	localparam int SPACE_BIT = 31;

	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [31:0] addr;
		logic [31:0] wdata;
	} core_req_t;

endpackage

//--- hw/fsab_credit_tracker.sv
/*
 * FSAB outbound credit counter.
 * Every outbound request lasts one cycle and costs one credit,
 * each returned credit adds one back.
 */
module fsab_credit_tracker
	import fsab_pkg::*;
(
	input  logic clk,
	input  logic rst_b,
	input  logic fsabo_credit,
	input  logic fsabo_valid,
	output logic credit_avail
);

	logic [FSAB_CREDIT_W-1:0] credits_q;
	logic [FSAB_CREDIT_W-1:0] credits_nxt;

	always_comb begin
		credits_nxt = credits_q;
		if (fsabo_credit)
			credits_nxt = credits_nxt + 1'b1; // credit came back
		if (fsabo_valid)
			credits_nxt = credits_nxt - 1'b1; // request went out
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			credits_q <= FSAB_INITIAL_CREDITS;
		end else begin
			credits_q <= credits_nxt;
		end
	end

	assign credit_avail = (credits_q != '0);

endmodule

//--- hw/dcache_store.sv
/*
 * Data cache storage.
 * Valid bits, tags and the high/low data halves of every beat.
 * Detects hits, registers the addressed word for the 4a stage,
 * applies write-through stores and line fill beats.
 */
module dcache_store
	import fsab_pkg::*;
	import dcache_pkg::*;
(
	input  logic        clk,
	input  logic        rst_b,
	input  core_req_t   core_req,
	output logic        hit,
	input  logic        fill_start,
	input  logic        fill_we,
	input  logic        fill_done,
	input  logic [31:0] fill_addr,
	input  logic [2:0]  fill_word,
	input  logic [63:0] fill_data,
	output logic [31:0] rd_word
);

	localparam int N_WORDS = N_LINES * FSAB_LINE_BEATS;

	logic [N_LINES-1:0] valid_q;
	logic [TAG_W-1:0]   tags [N_LINES];
	logic [31:0]        data_hi [N_WORDS]; // {line,word}
	logic [31:0]        data_lo [N_WORDS];

	logic [TAG_W-1:0]        tag_3a;
	logic [IDX_W-1:0]        idx_3a;
	logic [IDX_W+WORD_W-1:0] word_idx_3a;
	logic                    half_3a;
	logic                    access_hit;

	logic [TAG_W-1:0]        fill_tag;
	logic [IDX_W-1:0]        fill_idx;
	logic [IDX_W+WORD_W-1:0] fill_word_idx;

	assign tag_3a      = core_req.addr[TAG_LSB +: TAG_W];
	assign idx_3a      = core_req.addr[IDX_LSB +: IDX_W];
	assign word_idx_3a = {idx_3a, core_req.addr[WORD_LSB +: WORD_W]};
	assign half_3a     = core_req.addr[HALF_BIT];

	assign fill_tag      = fill_addr[TAG_LSB +: TAG_W];
	assign fill_idx      = fill_addr[IDX_LSB +: IDX_W];
	assign fill_word_idx = {fill_idx, fill_word};

	assign hit        = valid_q[idx_3a] && (tags[idx_3a] == tag_3a);
	assign access_hit = (core_req.rd || core_req.wr) && hit;

	// line state
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			valid_q <= '0;
		end else if (fill_start) begin
			valid_q[fill_idx] <= 1'b0; // line is being replaced
		end else if (fill_done) begin
			valid_q[fill_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_done)
			tags[fill_idx] <= fill_tag;
	end

	/*
	 * A fill only targets an invalid line, so the fill beat and a
	 * store hit never land on the same entry.
	 */
	always_ff @(posedge clk) begin
		if (fill_we) begin
			data_hi[fill_word_idx] <= fill_data[63:32];
			data_lo[fill_word_idx] <= fill_data[31:0];
		end
		if (access_hit && core_req.wr) begin
			if (half_3a)
				data_hi[word_idx_3a] <= core_req.wdata;
			else
				data_lo[word_idx_3a] <= core_req.wdata;
		end
	end

	// 4a read data holds the old contents on a store
	always_ff @(posedge clk) begin
		if (access_hit)
			rd_word <= half_3a ? data_hi[word_idx_3a] : data_lo[word_idx_3a];
	end

endmodule

//--- hw/dcache_fsab_issue.sv
/*
 * FSAB request issue and line fill sequencing.
 * A read miss starts an 8-beat line read, a write goes out as one
 * masked 8-byte write. Matching return beats are counted into
 * fill writes for the store.
 */
module dcache_fsab_issue
	import fsab_pkg::*;
	import dcache_pkg::*;
(
	input  logic        clk,
	input  logic        rst_b,
	input  core_req_t   core_req,
	input  logic        hit,
	input  logic        credit_avail,
	output logic        fsabo_valid,
	output fsab_req_t   fsabo,
	input  logic        fsabi_valid,
	input  fsab_rsp_t   fsabi,
	output logic        fill_start,
	output logic        fill_we,
	output logic        fill_done,
	output logic [31:0] fill_addr,
	output logic [2:0]  fill_word,
	output logic [63:0] fill_data
);

	logic              pending_q;
	logic [31:0]       line_addr_q;
	logic [WORD_W-1:0] beat_q;

	logic fsab_space;
	logic start_read;
	logic start_write;
	logic beat_ok;

	assign fsab_space  = !core_req.addr[SPACE_BIT];
	assign start_read  = core_req.rd && fsab_space && !hit && !pending_q && credit_avail;
	assign start_write = core_req.wr && fsab_space && credit_avail;

	always_comb begin
		fsabo_valid  = 1'b0;
		fsabo        = '0;
		fsabo.did    = FSAB_DID_CPU;
		fsabo.subdid = FSAB_SUBDID_CPU_DCACHE;
		if (start_read) begin // miss read wins over a write
			fsabo_valid = 1'b1;
			fsabo.mode  = FSAB_READ;
			fsabo.addr  = {core_req.addr[30:IDX_LSB], {IDX_LSB{1'b0}}};
			fsabo.len   = 4'(FSAB_LINE_BEATS);
		end else if (start_write) begin
			fsabo_valid = 1'b1;
			fsabo.mode  = FSAB_WRITE;
			fsabo.addr  = {core_req.addr[30:WORD_LSB], {WORD_LSB{1'b0}}};
			fsabo.len   = 4'd1;
			fsabo.data  = {core_req.wdata, core_req.wdata};
			fsabo.mask  = core_req.addr[HALF_BIT] ? 8'hF0 : 8'h0F;
		end
	end

	assign beat_ok = pending_q && fsabi_valid && (fsabi.did == FSAB_DID_CPU) &&
	                 (fsabi.subdid == FSAB_SUBDID_CPU_DCACHE);

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			pending_q <= 1'b0;
			beat_q    <= '0;
		end else if (start_read) begin
			pending_q <= 1'b1;
			beat_q    <= '0;
		end else if (beat_ok) begin
			beat_q <= beat_q + 1'b1;
			if (fill_done)
				pending_q <= 1'b0; // last beat in
		end
	end

	always_ff @(posedge clk) begin
		if (start_read)
			line_addr_q <= {core_req.addr[31:IDX_LSB], {IDX_LSB{1'b0}}};
	end

	// start uses the live address since the latch loads on the same edge
	assign fill_addr  = start_read ? {core_req.addr[31:IDX_LSB], {IDX_LSB{1'b0}}} : line_addr_q;
	assign fill_start = start_read;
	assign fill_we    = beat_ok;
	assign fill_word  = beat_q;
	assign fill_data  = fsabi.data;
	assign fill_done  = beat_ok && (beat_q == WORD_W'(FSAB_LINE_BEATS - 1));

endmodule

//--- hw/spam_initiator.sv
/*
 * SPAM sidechannel initiator.
 * Issues one transaction at a time and waits for the device or
 * the timeout, then hands back the registered response.
 */
module spam_initiator
	import fsab_pkg::*;
	import dcache_pkg::*;
(
	input  logic        clk,
	input  logic        rst_b,
	input  core_req_t   core_req,
	output logic        spamo_valid,
	output spam_req_t   spamo,
	input  logic        spami_busy_b,
	input  logic [31:0] spami_data,
	output logic        spam_wait,
	output logic [31:0] spam_rd_data
);

	logic       intrans_q;
	logic [7:0] timeout_q;
	logic       expired;

	assign spamo_valid = (core_req.rd || core_req.wr) && core_req.addr[SPACE_BIT] && !intrans_q;

	always_comb begin
		spamo      = '0;
		spamo.r_nw = core_req.rd;
		spamo.did  = core_req.addr[27:24];
		spamo.addr = core_req.addr[23:0];
		if (core_req.wr)
			spamo.data = core_req.wdata;
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			intrans_q <= 1'b0;
			timeout_q <= '0;
		end else if (spamo_valid) begin
			intrans_q <= 1'b1;
			timeout_q <= SPAM_TIMEOUT;
		end else if (spami_busy_b || (timeout_q == '0)) begin
			intrans_q <= 1'b0; // device done or gave up
		end else if (intrans_q) begin
			timeout_q <= timeout_q - 1'b1;
		end
	end

	assign expired   = intrans_q && (timeout_q == '0) && !spami_busy_b;
	assign spam_wait = !spami_busy_b && ((intrans_q && (timeout_q != '0)) || spamo_valid);

	// response for the 4a stage
	always_ff @(posedge clk) begin
		spam_rd_data <= expired ? SPAM_DEAD_DATA : spami_data;
	end

endmodule

//--- hw/dcache_top.sv
/*
 * Write-through data cache top level.
 * Ties the store, FSAB issue, credit and SPAM blocks together and
 * steers stall and read data between the FSAB and SPAM paths.
 */
module dcache_top
	import fsab_pkg::*;
	import dcache_pkg::*;
(
	input  logic        clk,
	input  logic        rst_b,
	input  core_req_t   core_req,
	output logic        rw_wait,
	output logic [31:0] rd_data,
	output logic        fsabo_valid,
	output fsab_req_t   fsabo,
	input  logic        fsabo_credit,
	input  logic        fsabi_valid,
	input  fsab_rsp_t   fsabi,
	output logic        spamo_valid,
	output spam_req_t   spamo,
	input  logic        spami_busy_b,
	input  logic [31:0] spami_data
);

	logic        credit_avail;
	logic        hit;
	logic        fill_start;
	logic        fill_we;
	logic        fill_done;
	logic [31:0] fill_addr;
	logic [2:0]  fill_word;
	logic [63:0] fill_data;
	logic [31:0] rd_word;
	logic        spam_wait;
	logic [31:0] spam_rd_data;
	logic        fsab_stall;
	logic        spam_sel_4a;

	fsab_credit_tracker credit_inst (
		.clk          (clk),
		.rst_b        (rst_b),
		.fsabo_credit (fsabo_credit),
		.fsabo_valid  (fsabo_valid),
		.credit_avail (credit_avail)
	);

	dcache_store store_inst (
		.clk        (clk),
		.rst_b      (rst_b),
		.core_req   (core_req),
		.hit        (hit),
		.fill_start (fill_start),
		.fill_we    (fill_we),
		.fill_done  (fill_done),
		.fill_addr  (fill_addr),
		.fill_word  (fill_word),
		.fill_data  (fill_data),
		.rd_word    (rd_word)
	);

	dcache_fsab_issue issue_inst (
		.clk          (clk),
		.rst_b        (rst_b),
		.core_req     (core_req),
		.hit          (hit),
		.credit_avail (credit_avail),
		.fsabo_valid  (fsabo_valid),
		.fsabo        (fsabo),
		.fsabi_valid  (fsabi_valid),
		.fsabi        (fsabi),
		.fill_start   (fill_start),
		.fill_we      (fill_we),
		.fill_done    (fill_done),
		.fill_addr    (fill_addr),
		.fill_word    (fill_word),
		.fill_data    (fill_data)
	);

	spam_initiator spam_inst (
		.clk          (clk),
		.rst_b        (rst_b),
		.core_req     (core_req),
		.spamo_valid  (spamo_valid),
		.spamo        (spamo),
		.spami_busy_b (spami_busy_b),
		.spami_data   (spami_data),
		.spam_wait    (spam_wait),
		.spam_rd_data (spam_rd_data)
	);

	// miss waits for the fill and a write waits for a credit
	assign fsab_stall = (core_req.rd && !hit) || (core_req.wr && !credit_avail);
	assign rw_wait    = core_req.addr[SPACE_BIT] ? spam_wait : fsab_stall;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			spam_sel_4a <= 1'b0;
		end else begin
			spam_sel_4a <= core_req.addr[SPACE_BIT];
		end
	end

	assign rd_data = spam_sel_4a ? spam_rd_data : rd_word; // 4a stage

endmodule

//--- test/dcache_tb.sv
/*
 * Testbench for the write-through data cache.
 * Runs the operations of the vector file against the cache with
 * models of FSAB memory, credit return and a SPAM device.
 */
module dcache_tb
	import fsab_pkg::*;
	import dcache_pkg::*;
();

	localparam logic [1:0] OP_R  = 2'd0;
	localparam logic [1:0] OP_W  = 2'd1;
	localparam logic [1:0] OP_SR = 2'd2; // bit 1 marks sidechannel ops
	localparam logic [1:0] OP_SW = 2'd3;

	typedef struct packed {
		logic [1:0]  op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] exp_data;
		logic [15:0] credit_delay;
		logic [7:0]  spam_delay;
		logic        spam_never;
		logic        stall; // read miss or write without credit
	} vec_t;

	logic        clk;
	logic        rst_b = 1'b0;
	core_req_t   core_req = '0;
	logic        rw_wait;
	logic [31:0] rd_data;
	logic        fsabo_valid;
	fsab_req_t   fsabo;
	logic        fsabo_credit = 1'b0;
	logic        fsabi_valid = 1'b0;
	fsab_rsp_t   fsabi = '0;
	logic        spamo_valid;
	spam_req_t   spamo;
	logic        spami_busy_b = 1'b0;
	logic [31:0] spami_data = '0;

	vec_t        vecs[$];
	longint      watch_limit = 0;
	integer      seed = 46839;
	int          credit_delay = 1;
	int          credit_due[$]; // cycle numbers of pending credit returns
	int          outstanding = 0;
	int          cycle = 0;
	logic [31:0] wlog_addr[$];  // latest matching entry wins
	logic [31:0] wlog_data[$];
	logic [31:0] fill_base;
	int          fill_gap;
	int          fill_beat;
	logic        fill_busy = 1'b0;
	int          spam_delay = 0;
	logic        spam_never = 1'b0;
	int          spam_left;
	logic        spam_busy = 1'b0;
	logic [31:0] spam_resp;

	dcache_top dcache_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_fsab_req(string name, fsab_req_t got, fsab_req_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_spam_req(string name, spam_req_t got, spam_req_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic expect_count(int num, string bus, int got, int exp);
		if (got != exp) begin
			$display("vector %0d expected %0d %s request(s) but saw %0d", num, exp, bus, got);
			abort_run();
		end
	endtask

	function automatic logic [31:0] mem_word(logic [31:0] a);
		logic [31:0] w;
		w = a ^ 32'hC0DE0000; // contents before any write
		foreach (wlog_addr[i])
			if (wlog_addr[i] == a)
				w = wlog_data[i];
		return w;
	endfunction

	task automatic apply_write(fsab_req_t req);
		if (req.mask[3:0] == 4'hF) begin
			wlog_addr.push_back({1'b0, req.addr});
			wlog_data.push_back(req.data[31:0]);
		end
		if (req.mask[7:4] == 4'hF) begin
			wlog_addr.push_back({1'b0, req.addr} + 32'd4);
			wlog_data.push_back(req.data[63:32]);
		end
	endtask

	always @(posedge clk) begin : memory_model
		fsab_rsp_t rsp;
		rsp = '0;
		rsp.did = FSAB_DID_CPU;
		rsp.subdid = FSAB_SUBDID_CPU_DCACHE;
		fsabi_valid <= 1'b0;
		if (fsabo_valid && fsabo.mode == FSAB_WRITE)
			apply_write(fsabo);
		if (fsabo_valid && fsabo.mode == FSAB_READ) begin
			fill_base = {1'b0, fsabo.addr};
			fill_gap = 1 + ({$random(seed)} % 6);
			fill_beat = 0;
			fill_busy = 1'b1;
		end else if (fill_busy && fill_gap > 0) begin
			fill_gap--;
			if (fill_gap == 0) begin
				rsp.did = 4'h3; // beat for another requester
				rsp.data = '1;
				fsabi_valid <= 1'b1;
				fsabi <= rsp;
			end
		end else if (fill_busy) begin
			rsp.data = {mem_word(fill_base + 32'(fill_beat * 8 + 4)),
			            mem_word(fill_base + 32'(fill_beat * 8))};
			fsabi_valid <= 1'b1;
			fsabi <= rsp;
			fill_beat++;
			if (fill_beat == 8)
				fill_busy = 1'b0;
		end
	end

	always @(posedge clk) begin : credit_model
		fsabo_credit <= 1'b0;
		if (fsabo_valid) begin
			credit_due.push_back(cycle + credit_delay);
			outstanding++;
			if (outstanding > 4) begin
				$display("more than 4 FSAB requests outstanding at cycle %0d", cycle);
				abort_run();
			end
		end
		if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
			void'(credit_due.pop_front());
			fsabo_credit <= 1'b1; // one credit per cycle
			outstanding--;
		end
		cycle++;
	end

	always @(posedge clk) begin : spam_device
		spami_busy_b <= 1'b0;
		if (spamo_valid) begin
			spam_left = spam_delay;
			spam_busy = !spam_never;
			spam_resp = {4'h8, spamo.did, spamo.addr} ^ 32'h5A5A5A5A; // window at 8xxxxxxx
		end else if (spam_busy && spam_left == 0) begin
			spami_busy_b <= 1'b1;
			spami_data <= spam_resp;
			spam_busy = 1'b0;
		end else if (spam_busy) begin
			spam_left--;
		end
	end

	task automatic run_vector(vec_t v, int num);
		core_req_t req;
		fsab_req_t fsab_got;
		fsab_req_t fsab_exp;
		spam_req_t spam_got;
		spam_req_t spam_exp;
		int        n_fsab;
		int        n_spam;
		int        n_wait;
		req = '0;
		req.rd = (v.op == OP_R) || (v.op == OP_SR);
		req.wr = (v.op == OP_W) || (v.op == OP_SW);
		req.addr = v.addr;
		req.wdata = v.wdata;
		n_fsab = 0;
		n_spam = 0;
		n_wait = 0;
		fsab_got = '0;
		spam_got = '0;
		credit_delay = v.credit_delay;
		spam_delay = v.spam_delay;
		spam_never = v.spam_never;
		@(posedge clk);
		core_req <= req;
		do begin
			@(negedge clk);
			if (fsabo_valid) begin
				n_fsab++;
				fsab_got = fsabo;
			end
			if (spamo_valid) begin
				n_spam++;
				spam_got = spamo;
			end
			if (rw_wait)
				n_wait++;
		end while (rw_wait);
		@(posedge clk); // request completes here
		core_req <= '0;
		@(negedge clk);
		if (req.rd)
			check_word("rd_data", rd_data, v.exp_data);
		if (v.op[1]) begin
			spam_exp = '0;
			spam_exp.r_nw = req.rd;
			spam_exp.did = v.addr[27:24];
			spam_exp.addr = v.addr[23:0];
			spam_exp.data = req.wr ? v.wdata : 32'h0;
			expect_count(num, "SPAM", n_spam, 1);
			expect_count(num, "FSAB", n_fsab, 0);
			check_spam_req("spamo", spam_got, spam_exp);
		end else begin
			fsab_exp = '0;
			fsab_exp.did = FSAB_DID_CPU;
			fsab_exp.subdid = FSAB_SUBDID_CPU_DCACHE;
			if (req.rd) begin
				fsab_exp.mode = FSAB_READ;
				fsab_exp.addr = {v.addr[30:6], 6'b0}; // whole line
				fsab_exp.len = 4'd8;
			end else begin
				fsab_exp.mode = FSAB_WRITE;
				fsab_exp.addr = {v.addr[30:3], 3'b0};
				fsab_exp.len = 4'd1;
				fsab_exp.data = {v.wdata, v.wdata};
				fsab_exp.mask = v.addr[2] ? 8'hF0 : 8'h0F;
			end
			expect_count(num, "FSAB", n_fsab, (req.wr || v.stall) ? 1 : 0);
			expect_count(num, "SPAM", n_spam, 0);
			if (n_fsab == 1)
				check_fsab_req("fsabo", fsab_got, fsab_exp);
			if ((n_wait > 0) != v.stall) begin
				$display("vector %0d stalled for %0d cycles against expectation", num, n_wait);
				abort_run();
			end
		end
	endtask

	initial begin : main
		int          fd;
		string       line;
		string       op_s;
		logic [31:0] a, wd, ex;
		int          cd, sd, fl;
		int          max_delay;
		vec_t        v;
		fd = $fopen("test/dcache_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open test/dcache_vectors.txt");
			abort_run();
		end
		max_delay = 0;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			if ($sscanf(line, "%s %h %h %h %d %d %d", op_s, a, wd, ex, cd, sd, fl) != 7)
				continue;
			v = '0;
			v.op = (op_s == "W") ? OP_W : (op_s == "SR") ? OP_SR : (op_s == "SW") ? OP_SW : OP_R;
			v.addr = a;
			v.wdata = wd;
			v.exp_data = ex;
			v.credit_delay = cd[15:0];
			v.spam_delay = sd[7:0];
			v.spam_never = (sd < 0);
			v.stall = fl[0];
			max_delay = (cd > max_delay) ? cd : max_delay;
			max_delay = (sd > max_delay) ? sd : max_delay;
			vecs.push_back(v);
		end
		$fclose(fd);
		watch_limit = longint'(vecs.size()) * (300 + max_delay) * 40;
		repeat (16) @(posedge clk);
		rst_b <= 1'b1;
		@(negedge clk);
		check_flag("rw_wait", rw_wait, 1'b0);
		check_flag("fsabo_valid", fsabo_valid, 1'b0);
		check_flag("spamo_valid", spamo_valid, 1'b0);
		foreach (vecs[i])
			run_vector(vecs[i], i + 1);
		if (vecs.size() == 0) begin
			$display("no operations were read from the vector file");
			abort_run();
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

	initial begin : watchdog
		wait (watch_limit > 0);
		#(watch_limit);
		$display("run did not finish within %0d time units", watch_limit);
		abort_run();
	end

endmodule

//--- test/dcache_vectors.txt
# op addr wdata expected_rdata (hex), credit_delay spam_delay flag (decimal)
# flag 1 means the FSAB op stalls (read miss or no credit), spam_delay -1 means no answer
R  00001000 00000000 c0de1000 3 0 1
R  00001004 00000000 c0de1004 3 0 0
W  00001008 11223344 00000000 3 0 0
R  00001008 00000000 11223344 3 0 0
W  0000200c 55667788 00000000 3 0 0
R  0000200c 00000000 55667788 3 0 1
R  00002008 00000000 c0de2008 3 0 0
R  00000040 00000000 c0de0040 3 0 1
R  00000440 00000000 c0de0440 3 0 1
R  00000044 00000000 c0de0044 3 0 1
R  00001010 00000000 c0de1010 3 0 1
W  00001010 deadbeef 00000000 3 0 0
R  00001010 00000000 deadbeef 3 0 0
R  00001008 00000000 11223344 3 0 0
R  00001410 00000000 c0de1410 3 0 1
R  00001010 00000000 deadbeef 3 0 1
W  00003000 01010101 00000000 150 0 0
W  00003004 02020202 00000000 150 0 0
W  00003008 03030303 00000000 150 0 0
W  0000300c 04040404 00000000 150 0 0
W  00003010 05050505 00000000 150 0 1
R  00003010 00000000 05050505 3 0 1
R  0000300c 00000000 04040404 3 0 0
SW 83001234 0badf00d 00000000 3 2 0
SR 83001234 00000000 d95a486e 3 0 0
SR 8500abcd 00000000 df5af197 3 5 0
SR 87000010 00000000 deaddead 3 -1 0
R  00001004 00000000 c0de1004 3 0 1

//--- flist.f
hw/fsab_pkg.sv
hw/dcache_pkg.sv
hw/fsab_credit_tracker.sv
hw/dcache_store.sv
hw/dcache_fsab_issue.sv
hw/spam_initiator.sv
hw/dcache_top.sv
test/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - hw/fsab_pkg.sv
  - hw/dcache_pkg.sv
  - hw/fsab_credit_tracker.sv
  - hw/dcache_store.sv
  - hw/dcache_fsab_issue.sv
  - hw/spam_initiator.sv
  - hw/dcache_top.sv
  - target: test
    files:
      - test/dcache_tb.sv
